//--- src/lpbk_pkg.sv
// *********************************************************
// shared widths, line geometry and encodings of the tester
// at most 128 lines; a line is four 32-bit words
// *********************************************************
package lpbk_pkg;

    // *********************************************************
    // widths and geometry
    // *********************************************************
    localparam int ADDR_W        = 20;              // line address width
    localparam int LINE_IDX_W    = 7;               // line index width
    localparam int NUM_LINES_MAX = 128;             // 2**LINE_IDX_W
    localparam int WORD_W        = 32;              // data word
    localparam int LINE_W        = 4 * WORD_W;      // word0 in lsbs
    localparam int SEED_W        = 8;               // seed byte
    localparam int ERR_FLAG_W    = 4;               // mismatch flag field

    // *********************************************************
    // seed lfsr
    // *********************************************************
    localparam logic [SEED_W-1:0] SEED_INIT = 8'h01;  // lfsr value out of reset
    localparam logic [SEED_W-1:0] LFSR_TAPS = 8'hb8;  // taps 7,5,4,3 into bit 0

    // per-line ownership states
    typedef enum logic [1:0] {
        SEND_RD = 2'd0,                             // may issue a read
        SEND_WR = 2'd1,                             // may issue a write, odd lines
        RD_PEND = 2'd2,                             // read in flight
        WR_PEND = 2'd3                              // write in flight
    } line_state_e;

    // sticky error report
    typedef enum logic [1:0] {
        ERR_NONE       = 2'd0,
        ERR_LINE_COUNT = 2'd1,                      // num_lines of 1 or less
        ERR_FPGA_DATA  = 2'd2,                      // odd line mismatch
        ERR_CPU_DATA   = 2'd3                       // even line mismatch
    } err_code_e;

    // error_flags bits
    // 0 seed word, 1 inverted seed word, 2 word0 address, 3 word2 address

endpackage

//--- src/lpbk_config.sv
// *********************************************************
// test configuration registers, one cycle behind the inputs
// num_lines of 1 or less is flagged, never corrected
// *********************************************************
`timescale 1ns/1ps

module lpbk_config (
    input  logic        Clk_400,
    input  logic        reset,
    input  logic        go,                 // start, hold high to run
    input  logic [31:0] num_lines,          // lines in the sweep
    input  logic [31:0] dst_addr,           // xor mask for address words
    output logic        run,                // registered go
    output logic [31:0] cfg_num_lines,
    output logic [31:0] cfg_dst_addr,
    output logic        line_count_bad      // illegal count while running
);

    always_ff @(posedge Clk_400)
    begin
        if (reset)
        begin
            run           <= 1'b0;
            cfg_num_lines <= 32'd0;
            cfg_dst_addr  <= 32'd0;
        end
        else
        begin
            run           <= go;
            cfg_num_lines <= num_lines;     // follows input while running
            cfg_dst_addr  <= dst_addr;
        end
    end

    // the sweep needs at least one odd and one even line
    always_comb
    begin
        line_count_bad = run && (cfg_num_lines <= 32'd1);
    end

endmodule

//--- src/line_tracker.sv
// *********************************************************
// ownership state per line, at most one request in flight
// completions carry no id, the line index matches them
// *********************************************************
`timescale 1ns/1ps

module line_tracker (
    input  logic                          Clk_400,
    input  logic                          reset,
    input  logic [lpbk_pkg::LINE_IDX_W-1:0] rd_idx,       // line offered for read
    input  logic [lpbk_pkg::LINE_IDX_W-1:0] wr_idx,       // line offered for write
    input  logic                          rd_issue,     // read accepted
    input  logic                          wr_issue,     // write accepted
    input  logic [lpbk_pkg::LINE_IDX_W-1:0] issue_rd_idx,
    input  logic [lpbk_pkg::LINE_IDX_W-1:0] issue_wr_idx,
    input  logic                          rd_cmp,       // read response strobe
    input  logic                          wr_cmp,       // write response strobe
    input  logic [lpbk_pkg::LINE_IDX_W-1:0] rd_cmp_idx,
    input  logic [lpbk_pkg::LINE_IDX_W-1:0] wr_cmp_idx,
    output logic                          rd_ok,
    output logic                          wr_ok
);
    import lpbk_pkg::*;

    line_state_e state [NUM_LINES_MAX];             // one fsm per line

    always_ff @(posedge Clk_400)
    begin
        if (reset)
        begin
            for (int i = 0; i < NUM_LINES_MAX; i++)
            begin
                state[i] <= i[0] ? SEND_WR : SEND_RD;   // odd lines fpga owned
            end
        end
        else
        begin
            // issues, send state to pending
            if (rd_issue && state[issue_rd_idx] == SEND_RD)
                state[issue_rd_idx] <= RD_PEND;
            if (wr_issue && state[issue_wr_idx] == SEND_WR)
                state[issue_wr_idx] <= WR_PEND;
            // completions, odd line goes back to writing
            if (rd_cmp && state[rd_cmp_idx] == RD_PEND)
                state[rd_cmp_idx] <= rd_cmp_idx[0] ? SEND_WR : SEND_RD;
            if (wr_cmp && state[wr_cmp_idx] == WR_PEND)
                state[wr_cmp_idx] <= SEND_RD;   // read back what was written
        end
    end

    always_comb
    begin
        rd_ok = (state[rd_idx] == SEND_RD);
        wr_ok = (state[wr_idx] == SEND_WR);
    end

endmodule

//--- src/req_sequencer.sv
// *********************************************************
// read/write sweeps; a request not sent in its cycle is lost
// and the line is retried on a later pass of the counter
// *********************************************************
`timescale 1ns/1ps

module req_sequencer (
    input  logic                          Clk_400,
    input  logic                          reset,
    input  logic                          run,
    input  logic [31:0]                   cfg_num_lines,
    input  logic [31:0]                   cfg_dst_addr,
    input  logic                          rd_ok,
    input  logic                          wr_ok,
    input  logic                          rd_sent,      // same cycle as rd_en
    input  logic                          wr_sent,      // same cycle as wr_en
    output logic [lpbk_pkg::LINE_IDX_W-1:0] rd_idx,
    output logic [lpbk_pkg::LINE_IDX_W-1:0] wr_idx,
    output logic                          rd_issue,
    output logic                          wr_issue,
    output logic [lpbk_pkg::LINE_IDX_W-1:0] issue_rd_idx,
    output logic [lpbk_pkg::LINE_IDX_W-1:0] issue_wr_idx,
    output logic                          rd_en,
    output logic [lpbk_pkg::ADDR_W-1:0]   rd_addr,
    output logic [lpbk_pkg::ADDR_W-1:0]   wr_addr,
    output logic                          wr_en,
    output logic [lpbk_pkg::LINE_W-1:0]   wr_data,
    output logic                          seed_we,
    output logic [lpbk_pkg::LINE_IDX_W-1:0] seed_waddr,
    output logic [lpbk_pkg::SEED_W-1:0]   seed_wdata
);
    import lpbk_pkg::*;

    logic [LINE_IDX_W-1:0] rd_cnt;                  // 0,1,..,n-1
    logic [LINE_IDX_W-1:0] wr_cnt;                  // 1,3,.. odd only
    logic [SEED_W-1:0]     seed;                    // lfsr
    logic [WORD_W-1:0]     wr_addr_word;            // address word of next write

    always_comb
    begin
        rd_idx       = rd_cnt;
        wr_idx       = wr_cnt;
        wr_addr_word = WORD_W'(wr_cnt) ^ cfg_dst_addr;
        rd_issue     = rd_en && rd_sent;
        wr_issue     = wr_en && wr_sent;
        seed_we      = wr_en;                       // unsent write leaves line in SEND_WR
        seed_waddr   = issue_wr_idx;
        seed_wdata   = wr_data[WORD_W+SEED_W-1:WORD_W];  // seed byte of word1
    end

    // *********************************************************
    // sweep counters and enables
    // *********************************************************
    always_ff @(posedge Clk_400)
    begin
        if (reset)
        begin
            rd_cnt <= '0;
            wr_cnt <= LINE_IDX_W'(1);
            seed   <= SEED_INIT;
            rd_en  <= 1'b0;
            wr_en  <= 1'b0;
        end
        else
        begin
            seed  <= {seed[SEED_W-2:0], ^(seed & LFSR_TAPS)};  // free running
            // line on the bus right now is not pending yet
            rd_en <= run && rd_ok && !(rd_en && issue_rd_idx == rd_cnt);
            wr_en <= run && wr_ok && !(wr_en && issue_wr_idx == wr_cnt);
            if (run)
            begin
                if (32'(rd_cnt) + 32'd1 < cfg_num_lines)
                    rd_cnt <= rd_cnt + 1'b1;
                else
                    rd_cnt <= '0;
                if (32'(wr_cnt) + 32'd2 < cfg_num_lines)
                    wr_cnt <= wr_cnt + 2'd2;
                else
                    wr_cnt <= LINE_IDX_W'(1);
            end
        end
    end

    // request payload qualified by the enables
    always_ff @(posedge Clk_400)
    begin
        issue_rd_idx <= rd_cnt;
        issue_wr_idx <= wr_cnt;
        rd_addr      <= ADDR_W'(rd_cnt);
        wr_addr      <= ADDR_W'(wr_cnt);
        wr_data      <= {{4{~seed}}, wr_addr_word, {4{seed}}, wr_addr_word};  // word3..word0
    end

endmodule

//--- src/seed_mem.sv
// *********************************************************
// seed byte per line, one-cycle read, contents undefined
// until a line has been written
// *********************************************************
`timescale 1ns/1ps

module seed_mem (
    input  logic                          Clk_400,
    input  logic                          we,
    input  logic [lpbk_pkg::LINE_IDX_W-1:0] waddr,
    input  logic [lpbk_pkg::LINE_IDX_W-1:0] raddr,
    input  logic [lpbk_pkg::SEED_W-1:0]   wdata,
    output logic [lpbk_pkg::SEED_W-1:0]   rdata
);
    import lpbk_pkg::*;

    logic [SEED_W-1:0] mem [NUM_LINES_MAX];         // simple dual port

    always_ff @(posedge Clk_400)
    begin
        if (we)
            mem[waddr] <= wdata;
        rdata <= mem[raddr];                        // old data on collision
    end

endmodule

//--- src/read_checker.sv
// *********************************************************
// read data check, two edges after rd_rsp_valid
// first failure latches until reset, later ones are ignored
// *********************************************************
`timescale 1ns/1ps

module read_checker (
    input  logic                              Clk_400,
    input  logic                              reset,
    input  logic [31:0]                       cfg_dst_addr,
    input  logic                              line_count_bad,
    input  logic                              rd_rsp_valid,
    input  logic [lpbk_pkg::ADDR_W-1:0]       rd_rsp_addr,
    input  logic [lpbk_pkg::LINE_W-1:0]       rd_rsp_data,
    input  logic [lpbk_pkg::SEED_W-1:0]       seed_rdata,
    output logic [lpbk_pkg::LINE_IDX_W-1:0]   seed_raddr,
    output logic                              error_valid,
    output lpbk_pkg::err_code_e               error_code,
    output logic [lpbk_pkg::ERR_FLAG_W-1:0]   error_flags,
    output logic [lpbk_pkg::WORD_W-1:0]       error_addr,
    output logic [lpbk_pkg::WORD_W-1:0]       error_rcvd,
    output logic [lpbk_pkg::WORD_W-1:0]       error_exp
);
    import lpbk_pkg::*;

    logic                  rsp_valid_q;
    logic                  rsp_odd_q;               // fpga owned line
    logic [LINE_W-1:0]     rsp_data_q;
    logic [WORD_W-1:0]     exp_addr_q;              // expected address word
    logic [WORD_W-1:0]     exp_seed;
    logic [WORD_W-1:0]     exp_inv;
    logic [WORD_W-1:0]     word [4];
    logic [ERR_FLAG_W-1:0] flags;
    logic                  fail;
    logic [WORD_W-1:0]     fail_rcvd;
    logic [WORD_W-1:0]     fail_exp;

    assign seed_raddr = rd_rsp_addr[LINE_IDX_W-1:0];   // lines up with the _q stage

    // stage 1, response beside the seed read
    always_ff @(posedge Clk_400)
    begin
        if (reset)
            rsp_valid_q <= 1'b0;
        else
            rsp_valid_q <= rd_rsp_valid;
        rsp_odd_q  <= rd_rsp_addr[0];
        rsp_data_q <= rd_rsp_data;
        exp_addr_q <= WORD_W'(rd_rsp_addr) ^ cfg_dst_addr;
    end

    // *********************************************************
    // compare
    // *********************************************************
    always_comb
    begin
        for (int w = 0; w < 4; w++)
        begin
            word[w] = rsp_data_q[w*WORD_W +: WORD_W];
        end
        exp_seed = {4{seed_rdata}};
        exp_inv  = {4{~seed_rdata}};
        flags[0] = rsp_odd_q && (word[1] != exp_seed);  // even lines hold cpu data
        flags[1] = rsp_odd_q && (word[3] != exp_inv);
        flags[2] = (word[0] != exp_addr_q);
        flags[3] = (word[2] != exp_addr_q);
        fail     = rsp_valid_q && (|flags) && !error_valid && !line_count_bad;
        // lowest failing word wins
        if (flags[2])
        begin
            fail_rcvd = word[0];
            fail_exp  = exp_addr_q;
        end
        else if (flags[0])
        begin
            fail_rcvd = word[1];
            fail_exp  = exp_seed;
        end
        else if (flags[3])
        begin
            fail_rcvd = word[2];
            fail_exp  = exp_addr_q;
        end
        else
        begin
            fail_rcvd = word[3];
            fail_exp  = exp_inv;
        end
    end

    // stage 2, sticky report
    always_ff @(posedge Clk_400)
    begin
        if (reset)
        begin
            error_valid <= 1'b0;
            error_code  <= ERR_NONE;
            error_flags <= '0;
        end
        else if (!error_valid)
        begin
            if (line_count_bad)
            begin
                error_valid <= 1'b1;
                error_code  <= ERR_LINE_COUNT;
            end
            else if (fail)
            begin
                error_valid <= 1'b1;
                error_code  <= rsp_odd_q ? ERR_FPGA_DATA : ERR_CPU_DATA;
                error_flags <= flags;
            end
        end
    end

    always_ff @(posedge Clk_400)
    begin
        if (fail)
        begin
            error_addr <= exp_addr_q;
            error_rcvd <= fail_rcvd;
            error_exp  <= fail_exp;
        end
    end

endmodule

//--- src/lpbk2_top.sv
// *********************************************************
// coherency loopback tester, odd lines written and read back,
// even lines read only; sent must answer in the enable cycle
// *********************************************************
`timescale 1ns/1ps

module lpbk2_top (
    input  logic                              Clk_400,
    input  logic                              reset,
    input  logic                              go,
    input  logic [31:0]                       num_lines,
    input  logic [31:0]                       dst_addr,
    output logic                              rd_en,
    output logic [lpbk_pkg::ADDR_W-1:0]       rd_addr,
    input  logic                              rd_sent,
    output logic                              wr_en,
    output logic [lpbk_pkg::ADDR_W-1:0]       wr_addr,
    output logic [lpbk_pkg::LINE_W-1:0]       wr_data,
    input  logic                              wr_sent,
    input  logic                              rd_rsp_valid,
    input  logic [lpbk_pkg::ADDR_W-1:0]       rd_rsp_addr,
    input  logic [lpbk_pkg::LINE_W-1:0]       rd_rsp_data,
    input  logic                              wr_rsp_valid,
    input  logic [lpbk_pkg::ADDR_W-1:0]       wr_rsp_addr,
    output logic                              error_valid,
    output lpbk_pkg::err_code_e               error_code,
    output logic [lpbk_pkg::ERR_FLAG_W-1:0]   error_flags,
    output logic [lpbk_pkg::WORD_W-1:0]       error_addr,
    output logic [lpbk_pkg::WORD_W-1:0]       error_rcvd,
    output logic [lpbk_pkg::WORD_W-1:0]       error_exp
);
    import lpbk_pkg::*;

    logic                  run;
    logic [31:0]           cfg_num_lines;
    logic [31:0]           cfg_dst_addr;
    logic                  line_count_bad;
    logic [LINE_IDX_W-1:0] rd_idx;
    logic [LINE_IDX_W-1:0] wr_idx;
    logic                  rd_ok;
    logic                  wr_ok;
    logic                  rd_issue;
    logic                  wr_issue;
    logic [LINE_IDX_W-1:0] issue_rd_idx;
    logic [LINE_IDX_W-1:0] issue_wr_idx;
    logic                  seed_we;
    logic [LINE_IDX_W-1:0] seed_waddr;
    logic [LINE_IDX_W-1:0] seed_raddr;
    logic [SEED_W-1:0]     seed_wdata;
    logic [SEED_W-1:0]     seed_rdata;

    lpbk_config u_config (
        .Clk_400        (Clk_400),
        .reset          (reset),
        .go             (go),
        .num_lines      (num_lines),
        .dst_addr       (dst_addr),
        .run            (run),
        .cfg_num_lines  (cfg_num_lines),
        .cfg_dst_addr   (cfg_dst_addr),
        .line_count_bad (line_count_bad)
    );

    line_tracker u_tracker (
        .Clk_400      (Clk_400),
        .reset        (reset),
        .rd_idx       (rd_idx),
        .wr_idx       (wr_idx),
        .rd_issue     (rd_issue),
        .wr_issue     (wr_issue),
        .issue_rd_idx (issue_rd_idx),
        .issue_wr_idx (issue_wr_idx),
        .rd_cmp       (rd_rsp_valid),
        .wr_cmp       (wr_rsp_valid),
        .rd_cmp_idx   (rd_rsp_addr[LINE_IDX_W-1:0]),    // response address names the line
        .wr_cmp_idx   (wr_rsp_addr[LINE_IDX_W-1:0]),
        .rd_ok        (rd_ok),
        .wr_ok        (wr_ok)
    );

    req_sequencer u_seq (
        .Clk_400       (Clk_400),
        .reset         (reset),
        .run           (run),
        .cfg_num_lines (cfg_num_lines),
        .cfg_dst_addr  (cfg_dst_addr),
        .rd_ok         (rd_ok),
        .wr_ok         (wr_ok),
        .rd_sent       (rd_sent),
        .wr_sent       (wr_sent),
        .rd_idx        (rd_idx),
        .wr_idx        (wr_idx),
        .rd_issue      (rd_issue),
        .wr_issue      (wr_issue),
        .issue_rd_idx  (issue_rd_idx),
        .issue_wr_idx  (issue_wr_idx),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .wr_addr       (wr_addr),
        .wr_en         (wr_en),
        .wr_data       (wr_data),
        .seed_we       (seed_we),
        .seed_waddr    (seed_waddr),
        .seed_wdata    (seed_wdata)
    );

    seed_mem u_seed_mem (
        .Clk_400 (Clk_400),
        .we      (seed_we),
        .waddr   (seed_waddr),
        .raddr   (seed_raddr),
        .wdata   (seed_wdata),
        .rdata   (seed_rdata)
    );

    read_checker u_checker (
        .Clk_400        (Clk_400),
        .reset          (reset),
        .cfg_dst_addr   (cfg_dst_addr),
        .line_count_bad (line_count_bad),
        .rd_rsp_valid   (rd_rsp_valid),
        .rd_rsp_addr    (rd_rsp_addr),
        .rd_rsp_data    (rd_rsp_data),
        .seed_rdata     (seed_rdata),
        .seed_raddr     (seed_raddr),
        .error_valid    (error_valid),
        .error_code     (error_code),
        .error_flags    (error_flags),
        .error_addr     (error_addr),
        .error_rcvd     (error_rcvd),
        .error_exp      (error_exp)
    );

endmodule

//--- testbench/tb_lpbk2.sv
// ************************************************************
// directed tests of the loopback tester against a memory model
// responses return in order 2 to 6 cycles after acceptance
// ************************************************************
`timescale 1ns/1ps

module tb_lpbk2;
    import lpbk_pkg::*;

    localparam int TEST_CYCLES = 5 * 4 + 20 + 2000 + 20 + 2 * 400;  // resets and all tests
    localparam int CYCLE_LIMIT = TEST_CYCLES * 6 / 5;   // plus 20 percent

    logic Clk_400;
    logic reset;
    logic go;
    logic [31:0] num_lines;
    logic [31:0] dst_addr;
    logic rd_en, wr_en, rd_sent, wr_sent;
    logic [ADDR_W-1:0] rd_addr, wr_addr, rd_rsp_addr, wr_rsp_addr;
    logic [LINE_W-1:0] wr_data, rd_rsp_data;
    logic rd_rsp_valid, wr_rsp_valid;
    logic error_valid;
    err_code_e error_code;
    logic [ERR_FLAG_W-1:0] error_flags;
    logic [WORD_W-1:0] error_addr, error_rcvd, error_exp;

    // memory model state
    logic [LINE_W-1:0] mem_line [NUM_LINES_MAX];
    logic [WORD_W-1:0] seed_word [NUM_LINES_MAX];       // word1 of last accepted write
    logic              pending [NUM_LINES_MAX];         // request in flight
    logic              wr_done [NUM_LINES_MAX];         // write completed and not read yet
    int rd_q_idx[$], rd_q_due[$], wr_q_idx[$], wr_q_due[$];
    int cycle, cycle_cnt, errors, failed_tests, tests_run, due;
    int rd_last_due, wr_last_due, idx, wr_count, rd_count;
    logic in_reset, hold_sent, corrupt_en, corrupt_seen;
    logic [31:0] nl, da, corrupt_line, corrupt_mask, corrupt_val, corrupt_seed;
    logic [31:0] addr_word, w0, w1, w2, w3;
    int corrupt_word;

    lpbk2_top DUT (.*);

    always #2 Clk_400 = ~Clk_400;                       // 4 ns period

    // ************************************************************
    // responder with sent strobes, request checks and responses
    // ************************************************************
    always @(posedge Clk_400)
    begin
        in_reset = reset;                               // stable since last drive
        nl = num_lines;
        da = dst_addr;
        cycle++;
        #1;
        rd_sent = 1'b0;
        wr_sent = 1'b0;
        rd_rsp_valid = 1'b0;
        wr_rsp_valid = 1'b0;
        if (in_reset)
        begin
            rd_q_idx.delete();
            rd_q_due.delete();
            wr_q_idx.delete();
            wr_q_due.delete();
            for (int i = 0; i < NUM_LINES_MAX; i++)
            begin
                addr_word = 32'(i) ^ da;                // cpu owned content
                mem_line[i] = {32'd0, addr_word, 32'd0, addr_word};
                seed_word[i] = 32'd0;
                pending[i] = 1'b0;
                wr_done[i] = 1'b0;
            end
        end
        else
        begin
            if (rd_en)
            begin
                idx = int'(rd_addr[LINE_IDX_W-1:0]);
                if (nl > 32'd1 && 32'(rd_addr) >= nl)
                    report_mismatch("rd_addr", 32'(rd_addr), nl - 32'd1);
                if (!hold_sent && ($urandom % 4) != 0)  // about 75 percent
                begin
                    rd_sent = 1'b1;
                    rd_count++;
                    if (pending[idx])
                        note_failure($sformatf("second request on line %0d", idx));
                    if (idx % 2 == 1 && !wr_done[idx])
                        note_failure($sformatf("odd line %0d read before write done", idx));
                    pending[idx] = 1'b1;
                    wr_done[idx] = 1'b0;
                    due = cycle + 2 + int'($urandom % 5);
                    if (rd_q_idx.size() > 0 && due <= rd_last_due)
                        due = rd_last_due + 1;          // in order and one per cycle
                    rd_last_due = due;
                    rd_q_idx.push_back(idx);
                    rd_q_due.push_back(due);
                end
            end
            if (wr_en)
            begin
                idx = int'(wr_addr[LINE_IDX_W-1:0]);
                w0 = wr_data[31:0];
                w1 = wr_data[63:32];
                w2 = wr_data[95:64];
                w3 = wr_data[127:96];
                addr_word = 32'(wr_addr) ^ da;
                if (nl > 32'd1 && (wr_addr[0] != 1'b1 || 32'(wr_addr) >= nl))
                    report_mismatch("wr_addr", 32'(wr_addr), nl - 32'd1);
                if (w0 != addr_word)
                    report_mismatch("wr_data word0", w0, addr_word);
                if (w2 != addr_word)
                    report_mismatch("wr_data word2", w2, addr_word);
                if (w1 != {4{w1[7:0]}})
                    report_mismatch("wr_data word1", w1, {4{w1[7:0]}});
                if (w3 != ~w1)
                    report_mismatch("wr_data word3", w3, ~w1);
                if (!hold_sent && ($urandom % 4) != 0)
                begin
                    wr_sent = 1'b1;
                    wr_count++;
                    if (pending[idx])
                        note_failure($sformatf("second request on line %0d", idx));
                    pending[idx] = 1'b1;
                    mem_line[idx] = wr_data;            // line unread until completion
                    seed_word[idx] = w1;
                    due = cycle + 2 + int'($urandom % 5);
                    if (wr_q_idx.size() > 0 && due <= wr_last_due)
                        due = wr_last_due + 1;
                    wr_last_due = due;
                    wr_q_idx.push_back(idx);
                    wr_q_due.push_back(due);
                end
            end
            if (rd_q_idx.size() > 0 && rd_q_due[0] <= cycle)
            begin
                idx = rd_q_idx.pop_front();
                void'(rd_q_due.pop_front());
                rd_rsp_valid = 1'b1;
                rd_rsp_addr = ADDR_W'(idx);
                rd_rsp_data = mem_line[idx];
                if (corrupt_en && 32'(idx) == corrupt_line)
                begin
                    rd_rsp_data[corrupt_word*32 +: 32] ^= corrupt_mask;
                    if (!corrupt_seen)
                    begin
                        corrupt_val = rd_rsp_data[corrupt_word*32 +: 32];
                        corrupt_seed = seed_word[idx];
                        corrupt_seen = 1'b1;
                    end
                end
                pending[idx] = 1'b0;
            end
            if (wr_q_idx.size() > 0 && wr_q_due[0] <= cycle)
            begin
                idx = wr_q_idx.pop_front();
                void'(wr_q_due.pop_front());
                wr_rsp_valid = 1'b1;
                wr_rsp_addr = ADDR_W'(idx);
                pending[idx] = 1'b0;
                wr_done[idx] = 1'b1;
            end
        end
    end

    // run limit
    always @(posedge Clk_400)
    begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("Error at %0t: %s got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge Clk_400);
        #1;                                             // drive after the edge
    endtask

    task automatic apply_reset();
        step(1);
        reset = 1'b1;
        go = 1'b0;
        corrupt_en = 1'b0;
        corrupt_seen = 1'b0;
        hold_sent = 1'b0;
        step(3);
        reset = 1'b0;
    endtask

    // waits for the sticky error and gives false on timeout
    task automatic wait_error(input int max_cycles, output bit seen);
        seen = 1'b0;
        for (int i = 0; i < max_cycles && !seen; i++)
        begin
            step(1);
            seen = error_valid;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before)
            $display("test %s: ok", name);
        else
        begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    // ************************************************************
    // directed tests
    // ************************************************************
    task automatic idle_after_reset();
        int e0;
        e0 = errors;
        apply_reset();
        for (int i = 0; i < 20; i++)
        begin
            step(1);
            if (rd_en)
                report_mismatch("rd_en", 32'(rd_en), 32'd0);
            if (wr_en)
                report_mismatch("wr_en", 32'(wr_en), 32'd0);
            if (error_valid)
                report_mismatch("error_valid", 32'(error_valid), 32'd0);
            if (error_code != ERR_NONE)
                report_mismatch("error_code", 32'(error_code), 32'(ERR_NONE));
        end
        finish_test("idle", e0);
    endtask

    task automatic sweep_eight_lines();
        int e0;
        e0 = errors;
        num_lines = 32'd8;
        dst_addr = 32'h0005_a000;
        apply_reset();
        wr_count = 0;
        rd_count = 0;
        go = 1'b1;
        step(2000);
        if (error_valid)
            report_mismatch("error_valid", 32'(error_valid), 32'd0);
        if (wr_count == 0 || rd_count == 0)
            note_failure("no reads or writes accepted during the sweep");
        finish_test("sweep", e0);
    endtask

    task automatic single_line_error();
        int e0;
        bit seen;
        e0 = errors;
        num_lines = 32'd1;
        apply_reset();
        hold_sent = 1'b1;                               // no traffic with a single line
        go = 1'b1;
        wait_error(20, seen);
        if (!seen)
            note_failure("no error for a line count of 1");
        else if (error_code != ERR_LINE_COUNT)
            report_mismatch("error_code", 32'(error_code), 32'(ERR_LINE_COUNT));
        finish_test("line_count", e0);
    endtask

    task automatic seed_corruption();
        int e0;
        bit seen;
        e0 = errors;
        num_lines = 32'd8;
        dst_addr = 32'h0000_0c30;
        apply_reset();
        corrupt_line = 32'd3;
        corrupt_word = 1;                               // seed word
        corrupt_mask = 32'h0000_0001;
        corrupt_en = 1'b1;
        go = 1'b1;
        wait_error(400, seen);
        if (!seen)
            note_failure("no error for a corrupted seed word");
        else
        begin
            if (error_code != ERR_FPGA_DATA)
                report_mismatch("error_code", 32'(error_code), 32'(ERR_FPGA_DATA));
            if (error_flags != 4'b0001)
                report_mismatch("error_flags", 32'(error_flags), 32'h1);
            if (error_rcvd != corrupt_val)
                report_mismatch("error_rcvd", error_rcvd, corrupt_val);
            if (error_exp != corrupt_seed)
                report_mismatch("error_exp", error_exp, corrupt_seed);
        end
        finish_test("fpga_corrupt", e0);
    endtask

    task automatic address_corruption();
        int e0;
        bit seen;
        e0 = errors;
        num_lines = 32'd8;
        dst_addr = 32'h0001_2340;
        apply_reset();
        corrupt_line = 32'd4;
        corrupt_word = 2;                               // second address word
        corrupt_mask = 32'h8000_0000;
        corrupt_en = 1'b1;
        go = 1'b1;
        wait_error(400, seen);
        if (!seen)
            note_failure("no error for a corrupted even line");
        else
        begin
            if (error_code != ERR_CPU_DATA)
                report_mismatch("error_code", 32'(error_code), 32'(ERR_CPU_DATA));
            if (error_flags != 4'b1000)
                report_mismatch("error_flags", 32'(error_flags), 32'h8);
            if (error_addr != (32'd4 ^ dst_addr))
                report_mismatch("error_addr", error_addr, 32'd4 ^ dst_addr);
        end
        finish_test("cpu_corrupt", e0);
    endtask

    initial
    begin
        void'($urandom(18));
        Clk_400 = 1'b0;
        reset = 1'b1;
        go = 1'b0;
        num_lines = 32'd8;
        dst_addr = 32'd0;
        rd_sent = 1'b0;
        wr_sent = 1'b0;
        rd_rsp_valid = 1'b0;
        rd_rsp_addr = '0;
        rd_rsp_data = '0;
        wr_rsp_valid = 1'b0;
        wr_rsp_addr = '0;
        hold_sent = 1'b0;
        corrupt_en = 1'b0;
        corrupt_seen = 1'b0;
        idle_after_reset();
        sweep_eight_lines();
        single_line_error();
        seed_corruption();
        address_corruption();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, failed_tests, errors);
        if (failed_tests == 0 && errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- files.f
src/lpbk_pkg.sv
src/lpbk_config.sv
src/line_tracker.sv
src/req_sequencer.sv
src/seed_mem.sv
src/read_checker.sv
src/lpbk2_top.sv
testbench/tb_lpbk2.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the loopback tester simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_lpbk2 \
    -f files.f -o sim_lpbk2 > build.log 2>&1 \
    && ./obj_dir/sim_lpbk2 > sim.log 2>&1 \
    || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

cat sim.log

grep -q "TB FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
